/* Makefile */
TOP = tb_acc_bridge

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f acc_bridge.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* acc_bridge.f */
cmd_pkg.sv
res_pkg.sv
ram_dualport.sv
pipeline_fifo_async.sv
cmd_decode.sv
acc_execute.sv
result_pack.sv
acc_bridge.sv
tb_clk_gen.sv
tb_checker.sv
tb_acc_bridge.sv

/* acc_bridge.sv */
`timescale 1ns/1ps

module acc_bridge #(
	parameter int FIFO_PTR_WIDTH = 3
) (
	input  logic                reset,
	input  logic                in_clk,
	input  logic                out_clk,

	input  logic                cmd_en,
	input  cmd_pkg::cmd_word_t  cmd,
	output logic                cmd_ready,

	output logic                res_en,
	output res_pkg::result_t    res,
	input  logic                res_ready
);

	// command fifo output
	logic               cf_en;
	cmd_pkg::cmd_word_t cf_data;
	logic               cf_ready;

	// decode to execute
	logic               req_en;
	cmd_pkg::exec_req_t req;
	logic               req_ready;

	// execute to pack
	logic               acc_en;
	res_pkg::result_t   acc_res;
	logic               acc_ready;

	// pack to result fifo
	logic               pk_en;
	res_pkg::result_t   pk_res;
	logic               pk_ready;

	// --------------------
	// in_clk to out_clk
	// --------------------

	pipeline_fifo_async #(
		.DATA_WIDTH ($bits(cmd_pkg::cmd_word_t)),
		.PTR_WIDTH  (FIFO_PTR_WIDTH)
	) u_cmd_fifo (
		.reset        (reset),
		.in_clk       (in_clk),
		.in_en        (cmd_en),
		.in_data      (cmd),
		.in_ready     (cmd_ready),
		.in_free_num  (),
		.out_clk      (out_clk),
		.out_en       (cf_en),
		.out_data     (cf_data),
		.out_ready    (cf_ready),
		.out_data_num ()
	);

	cmd_decode u_cmd_decode (
		.reset     (reset),
		.out_clk   (out_clk),
		.in_en     (cf_en),
		.cmd       (cf_data),
		.in_ready  (cf_ready),
		.req_en    (req_en),
		.req       (req),
		.req_ready (req_ready)
	);

	acc_execute u_acc_execute (
		.reset     (reset),
		.out_clk   (out_clk),
		.req_en    (req_en),
		.req       (req),
		.req_ready (req_ready),
		.acc_en    (acc_en),
		.acc_res   (acc_res),
		.acc_ready (acc_ready)
	);

	result_pack u_result_pack (
		.reset     (reset),
		.out_clk   (out_clk),
		.acc_en    (acc_en),
		.acc_res   (acc_res),
		.acc_ready (acc_ready),
		.res_en    (pk_en),
		.res       (pk_res),
		.res_ready (pk_ready)
	);

	// --------------------
	// out_clk to in_clk
	// --------------------

	pipeline_fifo_async #(
		.DATA_WIDTH ($bits(res_pkg::result_t)),
		.PTR_WIDTH  (FIFO_PTR_WIDTH)
	) u_res_fifo (
		.reset        (reset),
		.in_clk       (out_clk),
		.in_en        (pk_en),
		.in_data      (pk_res),
		.in_ready     (pk_ready),
		.in_free_num  (),
		.out_clk      (in_clk),
		.out_en       (res_en),
		.out_data     (res),
		.out_ready    (res_ready),
		.out_data_num ()
	);

endmodule

/* acc_execute.sv */
`timescale 1ns/1ps

module acc_execute (
	input  logic                reset,
	input  logic                out_clk,

	input  logic                req_en,
	input  cmd_pkg::exec_req_t  req,
	output logic                req_ready,

	output logic                acc_en,
	output res_pkg::result_t    acc_res,
	input  logic                acc_ready
);

	logic [res_pkg::ACC_WIDTH-1:0] acc;
	logic [res_pkg::ACC_WIDTH-1:0] acc_next;
	logic                          take;

	assign take      = req_en & req_ready;
	assign req_ready = ~acc_en | acc_ready;

	// --------------------
	// operation
	// --------------------

	always_comb begin
		case (req.op)
			cmd_pkg::OP_LOAD:  acc_next = req.operand;
			// add and sub wrap at the accumulator width
			cmd_pkg::OP_ADD:   acc_next = acc + req.operand;
			cmd_pkg::OP_SUB:   acc_next = acc - req.operand;
			cmd_pkg::OP_AND:   acc_next = acc & req.operand;
			cmd_pkg::OP_XOR:   acc_next = acc ^ req.operand;
			cmd_pkg::OP_SHIFT: acc_next = req.shift_dir ? (acc >> req.shift_amt)
				: (acc << req.shift_amt);
			default:           acc_next = acc;
		endcase
	end

	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			acc    <= '0;
			acc_en <= 1'b0;
		end else begin
			if (req_ready) begin
				acc_en <= req_en;
			end
			if (take) begin
				acc <= acc_next;
			end
		end
	end

	// sequence is stamped by the next stage
	always_ff @(posedge out_clk) begin
		if (take) begin
			acc_res.seq   <= '0;
			acc_res.value <= acc_next;
			acc_res.zero  <= (acc_next == '0);
			acc_res.neg   <= acc_next[res_pkg::ACC_WIDTH-1];
		end
	end

endmodule

/* cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
	input  logic                reset,
	input  logic                out_clk,

	input  logic                in_en,
	input  cmd_pkg::cmd_word_t  cmd,
	output logic                in_ready,

	output logic                req_en,
	output cmd_pkg::exec_req_t  req,
	input  logic                req_ready
);

	cmd_pkg::exec_req_t dec;

	// pick the payload form from the opcode
	always_comb begin
		dec    = '0;
		case (cmd.op)
			cmd_pkg::OP_LOAD,
			cmd_pkg::OP_ADD,
			cmd_pkg::OP_SUB,
			cmd_pkg::OP_AND,
			cmd_pkg::OP_XOR: begin
				dec.op      = cmd.op;
				dec.operand = {{3{cmd.payload.imm[12]}}, cmd.payload.imm};
			end
			cmd_pkg::OP_SHIFT: begin
				dec.op        = cmd_pkg::OP_SHIFT;
				dec.shift_dir = cmd.payload.shift.dir;
				dec.shift_amt = cmd.payload.shift.amount;
			end
			// read and unassigned codes
			default: begin
				dec.op = cmd_pkg::OP_READ;
			end
		endcase
	end

	assign in_ready = ~req_en | req_ready;

	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			req_en <= 1'b0;
		end else if (in_ready) begin
			req_en <= in_en;
		end
	end

	always_ff @(posedge out_clk) begin
		if (in_en && in_ready) begin
			req <= dec;
		end
	end

endmodule

/* cmd_pkg.sv */
package cmd_pkg;

	// --------------------
	// command opcodes
	// --------------------

	// code 3'd7 is unassigned and decodes as OP_READ
	typedef enum logic [2:0] {
		OP_LOAD  = 3'd0,
		OP_ADD   = 3'd1,
		OP_SUB   = 3'd2,
		OP_AND   = 3'd3,
		OP_XOR   = 3'd4,
		OP_SHIFT = 3'd5,
		OP_READ  = 3'd6
	} opcode_e;

	// --------------------
	// payload forms
	// --------------------

	// shift form, dir 0 shifts left
	typedef struct packed {
		logic       dir;
		logic [3:0] amount;
		logic [7:0] spare;
	} shift_arg_t;

	// same 13 bits, read as immediate or as shift arguments
	typedef union packed {
		logic signed [12:0] imm;
		shift_arg_t         shift;
	} cmd_payload_u;

	typedef struct packed {
		opcode_e      op;
		cmd_payload_u payload;
	} cmd_word_t;

	// decoded request handed to the accumulator stage
	typedef struct packed {
		opcode_e     op;
		logic [15:0] operand;
		logic        shift_dir;
		logic [3:0]  shift_amt;
	} exec_req_t;

endpackage

/* pipeline_fifo_async.sv */
`timescale 1ns/1ps

module pipeline_fifo_async #(
	parameter int DATA_WIDTH = 8,
	parameter int PTR_WIDTH  = 3
) (
	input  logic                  reset,

	input  logic                  in_clk,
	input  logic                  in_en,
	input  logic [DATA_WIDTH-1:0] in_data,
	output logic                  in_ready,
	output logic [PTR_WIDTH:0]    in_free_num,

	input  logic                  out_clk,
	output logic                  out_en,
	output logic [DATA_WIDTH-1:0] out_data,
	input  logic                  out_ready,
	output logic [PTR_WIDTH:0]    out_data_num
);

	localparam logic [PTR_WIDTH:0] DEPTH = (PTR_WIDTH + 1)'(1) << PTR_WIDTH;

	function automatic logic [PTR_WIDTH:0] bin_to_gray(input logic [PTR_WIDTH:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [PTR_WIDTH:0] gray_to_bin(input logic [PTR_WIDTH:0] g);
		logic [PTR_WIDTH:0] b;
		b[PTR_WIDTH] = g[PTR_WIDTH];
		for (int i = PTR_WIDTH - 1; i >= 0; i--) begin
			b[i] = b[i + 1] ^ g[i];
		end
		return b;
	endfunction

	// write side state
	logic [PTR_WIDTH:0]    wr_ptr;
	logic [PTR_WIDTH:0]    wr_ptr_next;
	logic [PTR_WIDTH:0]    wr_gray;
	logic [PTR_WIDTH:0]    wr_rgray_meta;
	logic [PTR_WIDTH:0]    wr_rgray_sync;
	logic [PTR_WIDTH:0]    wr_rptr;
	logic                  wr_full;
	logic                  wr_push;

	// read side state
	logic [PTR_WIDTH:0]    rd_ptr;
	logic [PTR_WIDTH:0]    rd_ptr_next;
	logic [PTR_WIDTH:0]    rd_gray;
	logic [PTR_WIDTH:0]    rd_wgray_meta;
	logic [PTR_WIDTH:0]    rd_wgray_sync;
	logic [PTR_WIDTH:0]    rd_wptr;
	logic                  rd_empty;
	logic                  rd_pop;
	logic                  ram_valid;
	logic                  hold_valid;
	logic [DATA_WIDTH-1:0] hold_data;
	logic [DATA_WIDTH-1:0] ram_rd_data;

	ram_dualport #(
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_WIDTH (PTR_WIDTH)
	) u_ram (
		.wr_clk  (in_clk),
		.wr_en   (wr_push),
		.wr_addr (wr_ptr[PTR_WIDTH-1:0]),
		.wr_data (in_data),
		.rd_clk  (out_clk),
		.rd_en   (~hold_valid | out_ready),
		.rd_addr (rd_ptr[PTR_WIDTH-1:0]),
		.rd_data (ram_rd_data)
	);

	// --------------------
	// write domain
	// --------------------

	assign wr_push     = in_en & in_ready;
	assign wr_ptr_next = wr_ptr + (PTR_WIDTH + 1)'(wr_push);

	always_ff @(posedge in_clk or posedge reset) begin
		if (reset) begin
			wr_ptr        <= '0;
			wr_gray       <= '0;
			wr_rgray_meta <= '0;
			wr_rgray_sync <= '0;
		end else begin
			wr_ptr        <= wr_ptr_next;
			// gray taken from a register so the crossing bus never glitches
			wr_gray       <= bin_to_gray(wr_ptr_next);
			wr_rgray_meta <= rd_gray;
			wr_rgray_sync <= wr_rgray_meta;
		end
	end

	assign wr_rptr = gray_to_bin(wr_rgray_sync);

	// full when the wrap bits differ and the addresses meet
	assign wr_full = (wr_ptr[PTR_WIDTH] != wr_rptr[PTR_WIDTH]) &&
		(wr_ptr[PTR_WIDTH-1:0] == wr_rptr[PTR_WIDTH-1:0]);

	assign in_ready    = ~wr_full;
	assign in_free_num = DEPTH - (wr_ptr - wr_rptr);

	// --------------------
	// read domain
	// --------------------

	assign rd_wptr     = gray_to_bin(rd_wgray_sync);
	assign rd_empty    = (rd_ptr == rd_wptr);
	assign rd_pop      = ~rd_empty & (out_ready | ~out_en);
	assign rd_ptr_next = rd_ptr + (PTR_WIDTH + 1)'(rd_pop);

	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			rd_ptr        <= '0;
			rd_gray       <= '0;
			rd_wgray_meta <= '0;
			rd_wgray_sync <= '0;
			ram_valid     <= 1'b0;
			hold_valid    <= 1'b0;
		end else begin
			rd_ptr        <= rd_ptr_next;
			rd_gray       <= bin_to_gray(rd_ptr_next);
			rd_wgray_meta <= wr_gray;
			rd_wgray_sync <= rd_wgray_meta;
			// ram output pairs with the slot read at this edge
			ram_valid     <= ~rd_empty;
			if (out_ready) begin
				hold_valid <= 1'b0;
			end else if (!hold_valid) begin
				hold_valid <= ram_valid;
			end
		end
	end

	// park the ram word while the sink stalls
	always_ff @(posedge out_clk) begin
		if (!out_ready && !hold_valid) begin
			hold_data <= ram_rd_data;
		end
	end

	assign out_en       = hold_valid | ram_valid;
	assign out_data     = hold_valid ? hold_data : ram_rd_data;
	assign out_data_num = rd_wptr - rd_ptr;

endmodule

/* ram_dualport.sv */
`timescale 1ns/1ps

module ram_dualport #(
	parameter int DATA_WIDTH = 8,
	parameter int ADDR_WIDTH = 3
) (
	input  logic                  wr_clk,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  logic [DATA_WIDTH-1:0] wr_data,

	input  logic                  rd_clk,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	// write port
	always_ff @(posedge wr_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read port, one cycle of latency
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* res_pkg.sv */
package res_pkg;

	parameter int ACC_WIDTH = 16;

	// --------------------
	// result record
	// --------------------

	// zero and neg describe the value field
	typedef struct packed {
		logic [7:0]           seq;
		logic [ACC_WIDTH-1:0] value;
		logic                 zero;
		logic                 neg;
	} result_t;

endpackage

/* result_pack.sv */
`timescale 1ns/1ps

module result_pack (
	input  logic              reset,
	input  logic              out_clk,

	input  logic              acc_en,
	input  res_pkg::result_t  acc_res,
	output logic              acc_ready,

	output logic              res_en,
	output res_pkg::result_t  res,
	input  logic              res_ready
);

	logic [7:0] seq_cnt;
	logic       take;

	assign acc_ready = ~res_en | res_ready;
	assign take      = acc_en & acc_ready;

	// counter wraps at 256 on its own
	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			res_en  <= 1'b0;
			seq_cnt <= '0;
		end else begin
			if (acc_ready) begin
				res_en <= acc_en;
			end
			if (take) begin
				seq_cnt <= seq_cnt + 8'd1;
			end
		end
	end

	always_ff @(posedge out_clk) begin
		if (take) begin
			res     <= acc_res;
			res.seq <= seq_cnt;
		end
	end

endmodule

/* tb_acc_bridge.sv */
`timescale 1ns/1ps

module tb_acc_bridge;

	localparam logic [31:0] SEED = 32'hb60a_4208;
	localparam int N_T1 = 9;
	localparam int N_T2 = 200;
	localparam int N_T3 = 64;
	localparam int N_T4 = 96;
	localparam int N_T5 = 300;
	localparam int TOTAL_CMDS = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;

	localparam logic [1:0] RDY_ON   = 2'd0;
	localparam logic [1:0] RDY_RAND = 2'd1;
	localparam logic [1:0] RDY_HOLD = 2'd2;

	logic             in_clk;
	logic             out_clk;
	logic             reset;
	logic             cmd_en;
	logic [15:0]      cmd;
	logic             cmd_ready;
	logic             res_en;
	res_pkg::result_t res;
	logic             res_ready;

	// model state and expected results
	logic [15:0]      m_acc;
	logic [7:0]       m_seq;
	logic             exp_push;
	res_pkg::result_t exp_data;
	int               full_events;

	logic [31:0]      stim_lfsr;
	logic [1:0]       rdy_mode;
	logic [31:0]      r;
	logic [31:0]      h;
	int               sent_cnt;
	int               tb_errors;
	int               rx_count;
	int               err_count;
	int               base;
	int               full_start;
	int               wait_cnt;

	tb_clk_gen #(.PERIOD_NS(4.0)) u_in_clk_gen (.clk(in_clk));
	tb_clk_gen #(.PERIOD_NS(6.0)) u_out_clk_gen (.clk(out_clk));

	acc_bridge #(
		.FIFO_PTR_WIDTH (3)
	) u_acc_bridge (
		.reset     (reset),
		.in_clk    (in_clk),
		.out_clk   (out_clk),
		.cmd_en    (cmd_en),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.res_en    (res_en),
		.res       (res),
		.res_ready (res_ready)
	);

	tb_checker u_checker (
		.in_clk    (in_clk),
		.reset     (reset),
		.exp_push  (exp_push),
		.exp_data  (exp_data),
		.res_en    (res_en),
		.res_ready (res_ready),
		.res       (res),
		.rx_count  (rx_count),
		.err_count (err_count)
	);

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
	endtask

	// accumulator rule per opcode with the payload read from the raw command bits
	function automatic logic [15:0] apply_cmd(input logic [15:0] acc, input logic [15:0] c);
		logic [15:0] imm;
		imm = {{3{c[12]}}, c[12:0]};
		case (c[15:13])
			3'd0:    return imm;
			3'd1:    return acc + imm;
			3'd2:    return acc - imm;
			3'd3:    return acc & imm;
			3'd4:    return acc ^ imm;
			3'd5:    return c[12] ? (acc >> c[11:8]) : (acc << c[11:8]);
			default: return acc;
		endcase
	endfunction

	task automatic send_cmd(input logic [2:0] op, input logic [12:0] payload,
			input logic [3:0] gap);
		cmd_en <= 1'b1;
		cmd    <= {op, payload};
		@(posedge in_clk);
		while (!cmd_ready) @(posedge in_clk);
		sent_cnt++;
		if (gap != 4'd0) begin
			cmd_en <= 1'b0;
			repeat (gap) @(posedge in_clk);
		end
	endtask

	task automatic finish_test(input string name, input int err_base);
		cmd_en <= 1'b0;
		while (rx_count < sent_cnt) @(posedge in_clk);
		$display("test %s: %0d results so far, %0d errors in this test",
			name, rx_count, err_count + tb_errors - err_base);
	endtask

	// --------------------
	// model
	// --------------------

	always @(posedge in_clk) begin
		if (reset) begin
			m_acc = '0;
			m_seq = '0;
			exp_push    <= 1'b0;
			full_events <= 0;
		end else begin
			exp_push <= 1'b0;
			if (cmd_en && cmd_ready) begin
				m_acc = apply_cmd(m_acc, cmd);
				exp_data.seq   <= m_seq;
				exp_data.value <= m_acc;
				exp_data.zero  <= (m_acc == 16'h0000);
				exp_data.neg   <= m_acc[15];
				exp_push       <= 1'b1;
				m_seq = m_seq + 8'd1;
			end
			if (cmd_en && !cmd_ready) begin
				full_events <= full_events + 1;
			end
		end
	end

	// res_ready source with its own lfsr state so it does not disturb the stimulus
	initial begin : ready_drive
		logic [31:0] rdy_lfsr;
		rdy_lfsr = SEED;
		res_ready <= 1'b0;
		forever begin
			@(posedge in_clk);
			case (rdy_mode)
				RDY_ON:   res_ready <= 1'b1;
				RDY_RAND: begin
					rdy_lfsr = lfsr_step(rdy_lfsr);
					res_ready <= rdy_lfsr[0];
				end
				default:  res_ready <= 1'b0;
			endcase
		end
	end

	initial begin : watchdog
		#(TOTAL_CMDS * 200);
		$display("timeout: %0d of %0d results received, results are missing",
			rx_count, sent_cnt);
		$display("Finished with errors");
		$finish;
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin
		reset       <= 1'b1;
		cmd_en      <= 1'b0;
		cmd         <= '0;
		rdy_mode    <= RDY_ON;
		stim_lfsr = SEED;
		sent_cnt  = 0;
		tb_errors = 0;
		repeat (16) @(posedge in_clk);
		reset <= 1'b0;
		@(posedge in_clk);

		// load then reads
		base = err_count + tb_errors;
		take_bits(13, r);
		send_cmd(3'd0, r[12:0], 4'd0);
		for (int i = 0; i < N_T1 - 1; i++) begin
			take_bits(13, r);
			send_cmd(3'd6, r[12:0], 4'd0);
		end
		finish_test("1 load and read", base);

		// alu ops with a load of zero now and then for the zero flag
		base = err_count + tb_errors;
		for (int i = 0; i < N_T2; i++) begin
			take_bits(17, r);
			if (i % 25 == 0) begin
				send_cmd(3'd0, 13'd0, {2'b00, r[16:15]});
			end else begin
				send_cmd({1'b0, r[1:0]} + 3'd1, r[14:2], {2'b00, r[16:15]});
			end
		end
		finish_test("2 add sub and xor", base);

		// every direction and amount with a fresh value before each
		base = err_count + tb_errors;
		for (int k = 0; k < N_T3 / 2; k++) begin
			take_bits(21, r);
			send_cmd(3'd0, r[12:0], 4'd0);
			send_cmd(3'd5, {k[4], k[3:0], r[20:13]}, 4'd0);
		end
		finish_test("3 shifts", base);

		// result path held until the command side backs up
		base = err_count + tb_errors;
		for (int round = 0; round < 3; round++) begin
			take_bits(7, h);
			rdy_mode   <= RDY_HOLD;
			full_start = full_events;
			fork
				begin
					for (int i = 0; i < N_T4 / 3; i++) begin
						take_bits(16, r);
						send_cmd(r[2:0], r[15:3], 4'd0);
					end
				end
				begin
					wait_cnt = 0;
					while (full_events == full_start && wait_cnt < 2000) begin
						@(posedge in_clk);
						wait_cnt++;
					end
					if (full_events == full_start) begin
						$display("cmd_ready never went low while res_ready was held low");
						tb_errors++;
					end
					repeat (32'(h[6:0]) + 32) @(posedge in_clk);
					rdy_mode <= RDY_RAND;
				end
			join
		end
		finish_test("4 back-pressure", base);

		// long mixed run with idle gaps
		base = err_count + tb_errors;
		rdy_mode <= RDY_RAND;
		for (int i = 0; i < N_T5; i++) begin
			take_bits(20, r);
			send_cmd(r[2:0], r[15:3], r[19] ? {1'b0, r[18:16]} : 4'd0);
		end
		finish_test("5 mixed traffic", base);

		// quiet period to catch any extra result
		rdy_mode <= RDY_ON;
		repeat (200) @(posedge in_clk);
		if (rx_count != sent_cnt) begin
			$display("received %0d results for %0d commands", rx_count, sent_cnt);
			tb_errors++;
		end

		$display("tests 5, commands %0d, results %0d, errors %0d",
			sent_cnt, rx_count, err_count + tb_errors);
		if (err_count + tb_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
	input  logic             in_clk,
	input  logic             reset,
	input  logic             exp_push,
	input  res_pkg::result_t exp_data,
	input  logic             res_en,
	input  logic             res_ready,
	input  res_pkg::result_t res,
	output int               rx_count,
	output int               err_count
);

	res_pkg::result_t exp_q [$];
	res_pkg::result_t exp_r;

	task automatic check_field(input string name, input logic [15:0] exp_v,
			input logic [15:0] got_v);
		if (exp_v !== got_v) begin
			$display("[ERROR] time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, exp_v, got_v);
			err_count++;
		end
	endtask

	// --------------------
	// compare on each result transfer
	// --------------------

	always @(posedge in_clk) begin
		if (reset) begin
			rx_count  = 0;
			err_count = 0;
			exp_q.delete();
		end else begin
			if (exp_push) begin
				exp_q.push_back(exp_data);
			end
			if (res_en && res_ready) begin
				rx_count++;
				if (exp_q.size() == 0) begin
					$display("time %0t: a result arrived with no command left to match it",
						$time);
					err_count++;
				end else begin
					exp_r = exp_q.pop_front();
					check_field("res.seq", {8'h00, exp_r.seq}, {8'h00, res.seq});
					check_field("res.value", exp_r.value, res.value);
					check_field("res.zero", {15'd0, exp_r.zero}, {15'd0, res.zero});
					check_field("res.neg", {15'd0, exp_r.neg}, {15'd0, res.neg});
				end
			end
		end
	end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule
